/* hdl/hps_io_pkg.sv */
// Shared widths, host command codes, identification word and the host data word union
package hps_io_pkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int unsigned io_word_w  = 16;
	localparam int unsigned osd_addr_w = 8;
	localparam int unsigned osd_data_w = 8;

	// Signature in the top 24 bits, core type below
	localparam logic [31:0] core_magic = {24'h5CA623, 8'hA5};

	// ==================================================
	// Host command codes
	// ==================================================
	localparam logic [7:0] cmd_cfg_wr = 8'd1;
	localparam logic [7:0] cmd_cfg_rd = 8'd2;
	localparam logic [7:0] cmd_osd_wr = 8'd3;

	// One host data word, decoded per command
	typedef union packed {
		struct packed {
			logic [8:0] rsv_hi;
			logic       audio_96k;
			logic       ypbpr_en;
			logic       rsv_4;
			logic       csync;
			logic       vga_scaler;
			logic [1:0] rsv_lo;
		} cfg;
		struct packed {
			logic [osd_addr_w-1:0] osd_addr;
			logic [osd_data_w-1:0] osd_data;
		} osd;
	} io_word_u;

endpackage

/* hdl/hps_io_sync.sv */
// Host port front end: registers gp_out, turns strobes into words with acknowledge, builds gp_in
`timescale 1ns/1ns

module hps_io_sync (
	input  logic                               FPGA_CLK2_50,
	input  logic                               resetd,
	input  logic [31:0]                        gp_out,
	input  logic                               word_ready,
	input  logic [hps_io_pkg::io_word_w-1:0]   io_dout,
	input  logic                               btn_user,
	input  logic                               btn_osd,
	output logic [31:0]                        gp_out_r,
	output logic                               word_valid,
	output logic [hps_io_pkg::io_word_w-1:0]   word_data,
	output logic                               word_frame,
	output logic [31:0]                        gp_in
);

	// Standard I/O protocol, narrow words
	localparam logic [1:0] io_ver  = 2'd0;
	localparam logic       io_wide = 1'b0;

	logic [31:0] gp_out_d;
	logic        rack;
	logic        io_ack;
	logic        io_clk;
	logic        waiting;

	assign io_clk     = gp_out_r[17];
	assign word_frame = gp_out_r[20];
	// Word still pending in front of the decoder
	assign waiting    = word_valid & ~word_ready;

	// Two stage capture of the host word
	always_ff @(posedge FPGA_CLK2_50) begin
		gp_out_d <= gp_out;
		gp_out_r <= gp_out_d;
	end

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			rack       <= 1'b0;
			io_ack     <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			if (word_valid && word_ready)
				word_valid <= 1'b0;
			// Acknowledge freezes while the decoder holds off
			if (!waiting) begin
				rack   <= io_clk;
				io_ack <= rack;
				if (io_clk && !rack)
					word_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge FPGA_CLK2_50) begin
		if (!waiting && io_clk && !rack)
			word_data <= gp_out_r[hps_io_pkg::io_word_w-1:0];
	end

	assign gp_in = gp_out[31] ? hps_io_pkg::core_magic :
		{1'b0, btn_user, btn_osd, 9'd0, io_ver, io_ack, io_wide, io_dout};

	// Offered word must not change before the decoder takes it
	a_word_hold: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		word_valid && !word_ready |=> $stable(word_data));

endmodule

/* hdl/hps_cmd_decoder.sv */
// Host command decoder: command word then data words, config register, OSD write requests
`timescale 1ns/1ns

module hps_cmd_decoder (
	input  logic                                FPGA_CLK2_50,
	input  logic                                resetd,
	input  logic                                word_valid,
	input  logic [hps_io_pkg::io_word_w-1:0]    word_data,
	input  logic                                word_frame,
	input  logic                                wr_ready,
	output logic                                word_ready,
	output logic                                wr_valid,
	output logic [hps_io_pkg::osd_addr_w-1:0]   wr_addr,
	output logic [hps_io_pkg::osd_data_w-1:0]   wr_data,
	output logic [hps_io_pkg::io_word_w-1:0]    cfg_word,
	output logic                                cfg_ready,
	output logic [hps_io_pkg::io_word_w-1:0]    io_dout
);

	hps_io_pkg::io_word_u dw;
	hps_io_pkg::io_word_u cfg_q;
	logic [7:0]           cmd;
	logic                 has_cmd;
	logic                 accept;
	logic                 data_word;

	assign dw         = word_data;
	assign cfg_word   = cfg_q;
	// No new word while an OSD write is waiting for the memory
	assign word_ready = ~wr_valid;
	assign accept     = word_valid & word_ready;
	assign data_word  = accept & word_frame & has_cmd;

	// ==================================================
	// Command state and configuration
	// ==================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			cmd       <= '0;
			cfg_q     <= '0;
			cfg_ready <= 1'b0;
			wr_valid  <= 1'b0;
		end else begin
			if (wr_valid && wr_ready)
				wr_valid <= 1'b0;
			if (!word_frame) begin
				has_cmd <= 1'b0;
			end else if (accept && !has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= dw[7:0];
			end else if (data_word) begin
				case (cmd)
					hps_io_pkg::cmd_cfg_wr: begin
						cfg_q.cfg <= dw.cfg;
						cfg_ready <= 1'b1;
					end
					hps_io_pkg::cmd_osd_wr: wr_valid <= 1'b1;
					// Unknown codes just swallow their data
					default: ;
				endcase
			end
		end
	end

	// Read-back word and OSD payload
	always_ff @(posedge FPGA_CLK2_50) begin
		if (data_word && cmd == hps_io_pkg::cmd_cfg_rd)
			io_dout <= cfg_q;
		if (data_word && cmd == hps_io_pkg::cmd_osd_wr) begin
			wr_addr <= dw.osd.osd_addr;
			wr_data <= dw.osd.osd_data;
		end
	end

	// New OSD writes only start from a word taken inside a frame
	a_wr_in_frame: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		$rose(wr_valid) |-> $past(word_valid && word_ready && word_frame));

endmodule

/* hdl/osd_ram_arbiter.sv */
// OSD byte memory shared by the host writer and the video reader under round-robin grant
`timescale 1ns/1ns

module osd_ram_arbiter #(
	parameter int OSD_DEPTH = 256
) (
	input  logic                                FPGA_CLK2_50,
	input  logic                                resetd,
	input  logic                                wr_valid,
	input  logic [hps_io_pkg::osd_addr_w-1:0]   wr_addr,
	input  logic [hps_io_pkg::osd_data_w-1:0]   wr_data,
	input  logic                                rd_valid,
	input  logic [hps_io_pkg::osd_addr_w-1:0]   rd_addr,
	output logic                                wr_ready,
	output logic                                rd_ready,
	output logic                                rd_data_valid,
	output logic [hps_io_pkg::osd_data_w-1:0]   rd_data
);

	logic [hps_io_pkg::osd_data_w-1:0] mem [0:OSD_DEPTH-1];
	// Set when the write port had the last grant
	logic                              last_wr;

	// ==================================================
	// Round-robin grant
	// ==================================================
	assign wr_ready = wr_valid & (~rd_valid | ~last_wr);
	assign rd_ready = rd_valid & (~wr_valid | last_wr);

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			last_wr       <= 1'b0;
			rd_data_valid <= 1'b0;
		end else begin
			rd_data_valid <= rd_ready;
			if (wr_ready)
				last_wr <= 1'b1;
			else if (rd_ready)
				last_wr <= 1'b0;
		end
	end

	// ==================================================
	// Single port memory, one access per cycle
	// ==================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (wr_ready)
			mem[wr_addr] <= wr_data;
		else if (rd_ready)
			rd_data <= mem[rd_addr];
	end

	a_one_grant: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		!(wr_ready && rd_ready));

	// A held write never loses twice in a row
	a_wr_fair: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		(wr_valid && !wr_ready) ##1 wr_valid |-> wr_ready);

endmodule

/* hdl/panel_io.sv */
// Panel buttons with sampled debounce, and drive of the power, disk and user LEDs
`timescale 1ns/1ns

module panel_io #(
	parameter int DEB_DIV = 100000
) (
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,
	input  logic       btn_user_n,
	input  logic       btn_osd_n,
	input  logic [1:0] key,
	input  logic       disk_req,
	input  logic [1:0] led_power_st,
	input  logic [1:0] led_disk_st,
	input  logic       led_user_st,
	output logic       btn_user,
	output logic       btn_osd,
	output logic       led_power,
	output logic       led_disk,
	output logic       led_user
);

	localparam int div_w = $clog2(DEB_DIV + 1);

	logic [div_w-1:0] div;
	logic [1:0]       raw;
	logic [7:0]       hist [2];
	logic [1:0]       deb;

	// Index 1 is the user button, index 0 the OSD button
	assign raw      = {~(btn_user_n & key[1]), ~(btn_osd_n & key[0])};
	assign btn_user = deb[1];
	assign btn_osd  = deb[0];

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			div     <= '0;
			hist[0] <= '0;
			hist[1] <= '0;
			deb     <= '0;
		end else begin
			if (div == div_w'(DEB_DIV))
				div <= '0;
			else
				div <= div + 1'b1;
			if (div == '0) begin
				for (int i = 0; i < 2; i++) begin
					hist[i] <= {hist[i][6:0], raw[i]};
					// Eight equal samples switch the state
					if (&hist[i])
						deb[i] <= 1'b1;
					if (hist[i] == '0)
						deb[i] <= 1'b0;
				end
			end
		end
	end

	// Bit 1 set means the core drives the LED directly, inverted
	assign led_power = led_power_st[1] ? ~led_power_st[0] : 1'b0;
	assign led_disk  = led_disk_st[1] ? ~led_disk_st[0] : (led_disk_st[0] | disk_req);
	assign led_user  = led_user_st;

endmodule

/* hdl/reset_ctl.sv */
// Reset request latch controlled by a two-bit code sequence from the host
`timescale 1ns/1ns

module reset_ctl (
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,
	input  logic [1:0] reset_code,
	output logic       reset_req
);

	logic [1:0] code_d;
	logic [1:0] code_d2;

	// History of the last two codes
	always_ff @(posedge FPGA_CLK2_50) begin
		code_d  <= reset_code;
		code_d2 <= code_d;
	end

	// ==================================================
	// Set on code 1, clear only on code 0 then code 2
	// ==================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			reset_req <= 1'b0;
		end else begin
			if (code_d == 2'd1)
				reset_req <= 1'b1;
			// A stray 2 right after 1 keeps the request
			if (code_d == 2'd2 && code_d2 == 2'd0)
				reset_req <= 1'b0;
		end
	end

endmodule

/* hdl/hps_io_top.sv */
// Host I/O block top: host port, command decoder, OSD memory, panel I/O and reset control
`timescale 1ns/1ns

module hps_io_top #(
	parameter int DEB_DIV   = 100000,
	parameter int OSD_DEPTH = 256
) (
	input  logic                                FPGA_CLK2_50,
	input  logic                                resetd,
	input  logic [31:0]                         gp_out,
	input  logic                                btn_user_n,
	input  logic                                btn_osd_n,
	input  logic [1:0]                          key,
	input  logic                                vid_rd_valid,
	input  logic [hps_io_pkg::osd_addr_w-1:0]   vid_rd_addr,
	input  logic [1:0]                          led_power_st,
	input  logic [1:0]                          led_disk_st,
	input  logic                                led_user_st,
	output logic [31:0]                         gp_in,
	output logic                                vid_rd_ready,
	output logic                                vid_rd_data_valid,
	output logic [hps_io_pkg::osd_data_w-1:0]   vid_rd_data,
	output logic                                cfg_ready,
	output logic                                audio_96k,
	output logic                                ypbpr_en,
	output logic                                csync,
	output logic                                vga_scaler,
	output logic                                led_power,
	output logic                                led_disk,
	output logic                                led_user,
	output logic                                reset_req
);

	logic [31:0]                       gp_out_r;
	logic                              word_valid;
	logic                              word_ready;
	logic [hps_io_pkg::io_word_w-1:0]  word_data;
	logic                              word_frame;
	logic [hps_io_pkg::io_word_w-1:0]  io_dout;
	logic                              wr_valid;
	logic                              wr_ready;
	logic [hps_io_pkg::osd_addr_w-1:0] wr_addr;
	logic [hps_io_pkg::osd_data_w-1:0] wr_data;
	logic [hps_io_pkg::io_word_w-1:0]  cfg_word;
	hps_io_pkg::io_word_u              cfg_u;
	logic                              btn_user;
	logic                              btn_osd;

	// ==================================================
	// Host side
	// ==================================================
	hps_io_sync u_sync (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.gp_out       (gp_out),
		.word_ready   (word_ready),
		.io_dout      (io_dout),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.gp_out_r     (gp_out_r),
		.word_valid   (word_valid),
		.word_data    (word_data),
		.word_frame   (word_frame),
		.gp_in        (gp_in)
	);

	hps_cmd_decoder u_decoder (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.word_valid   (word_valid),
		.word_data    (word_data),
		.word_frame   (word_frame),
		.wr_ready     (wr_ready),
		.word_ready   (word_ready),
		.wr_valid     (wr_valid),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.cfg_word     (cfg_word),
		.cfg_ready    (cfg_ready),
		.io_dout      (io_dout)
	);

	// OSD memory between host writer and video reader
	osd_ram_arbiter #(
		.OSD_DEPTH (OSD_DEPTH)
	) u_osd_ram (
		.FPGA_CLK2_50  (FPGA_CLK2_50),
		.resetd        (resetd),
		.wr_valid      (wr_valid),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.rd_valid      (vid_rd_valid),
		.rd_addr       (vid_rd_addr),
		.wr_ready      (wr_ready),
		.rd_ready      (vid_rd_ready),
		.rd_data_valid (vid_rd_data_valid),
		.rd_data       (vid_rd_data)
	);

	// ==================================================
	// Board side
	// ==================================================
	panel_io #(
		.DEB_DIV (DEB_DIV)
	) u_panel (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.btn_user_n   (btn_user_n),
		.btn_osd_n    (btn_osd_n),
		.key          (key),
		.disk_req     (gp_out_r[29]),
		.led_power_st (led_power_st),
		.led_disk_st  (led_disk_st),
		.led_user_st  (led_user_st),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.led_power    (led_power),
		.led_disk     (led_disk),
		.led_user     (led_user)
	);

	reset_ctl u_reset (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.reset_code   (gp_out_r[31:30]),
		.reset_req    (reset_req)
	);

	// Named video options out of the config word
	assign cfg_u      = cfg_word;
	assign audio_96k  = cfg_u.cfg.audio_96k;
	assign ypbpr_en   = cfg_u.cfg.ypbpr_en;
	assign csync      = cfg_u.cfg.csync;
	assign vga_scaler = cfg_u.cfg.vga_scaler;

endmodule

/* tb/tb_hps_io.sv */
// Host I/O block testbench, drives host transfers, video reads and panel inputs against a model
`timescale 1ns/1ns

module tb_hps_io;

	localparam int clk_period  = 40;
	localparam int deb_div     = 20;
	localparam int ack_limit   = 64;
	localparam int rd_limit    = 8;
	localparam int n_tests     = 6;
	// Longest test moves at most this many host words
	localparam int max_words   = 64;
	localparam int word_cycles = 2 * (ack_limit + 2);
	localparam int watchdog_cycles = n_tests * max_words * word_cycles;

	logic        FPGA_CLK2_50;
	logic        resetd;
	logic [31:0] gp_out;
	logic        btn_user_n;
	logic        btn_osd_n;
	logic [1:0]  key;
	logic        vid_rd_valid;
	logic [7:0]  vid_rd_addr;
	logic [1:0]  led_power_st;
	logic [1:0]  led_disk_st;
	logic        led_user_st;
	logic [31:0] gp_in;
	logic        vid_rd_ready;
	logic        vid_rd_data_valid;
	logic [7:0]  vid_rd_data;
	logic        cfg_ready;
	logic        audio_96k;
	logic        ypbpr_en;
	logic        csync;
	logic        vga_scaler;
	logic        led_power;
	logic        led_disk;
	logic        led_user;
	logic        reset_req;

	// Reference model and bookkeeping
	logic [7:0]  mem_model [256];
	logic [7:0]  exp_q [$];
	logic [7:0]  lo_addrs [$];
	logic [7:0]  hi_addrs [$];
	logic [1:0]  code_q [$];
	logic [7:0]  exp_byte;
	logic [7:0]  addr_v;
	logic [7:0]  data_v;
	logic [15:0] cfg_m;
	logic [3:0]  exp_flags;
	logic [1:0]  prev_code;
	logic        req_m;
	logic        bu_n;
	logic        bo_n;
	logic [1:0]  key_v;
	logic [1:0]  ps;
	logic [1:0]  ds;
	logic        us;
	logic        dr;
	logic [2:0]  exp_led;
	logic        hammer_on;
	string       test_name;
	int          err_count;
	int          pass_count;
	int          fail_count;
	int          errs_at_start;
	int          rd_start;
	int          rd_err_count = 0;
	int          rd_count = 0;

	hps_io_top #(
		.DEB_DIV   (deb_div),
		.OSD_DEPTH (256)
	) UUT (
		.FPGA_CLK2_50      (FPGA_CLK2_50),
		.resetd            (resetd),
		.gp_out            (gp_out),
		.btn_user_n        (btn_user_n),
		.btn_osd_n         (btn_osd_n),
		.key               (key),
		.vid_rd_valid      (vid_rd_valid),
		.vid_rd_addr       (vid_rd_addr),
		.led_power_st      (led_power_st),
		.led_disk_st       (led_disk_st),
		.led_user_st       (led_user_st),
		.gp_in             (gp_in),
		.vid_rd_ready      (vid_rd_ready),
		.vid_rd_data_valid (vid_rd_data_valid),
		.vid_rd_data       (vid_rd_data),
		.cfg_ready         (cfg_ready),
		.audio_96k         (audio_96k),
		.ypbpr_en          (ypbpr_en),
		.csync             (csync),
		.vga_scaler        (vga_scaler),
		.led_power         (led_power),
		.led_disk          (led_disk),
		.led_user          (led_user),
		.reset_req         (reset_req)
	);

	initial begin
		FPGA_CLK2_50 = 1'b0;
		forever #(clk_period / 2) FPGA_CLK2_50 = ~FPGA_CLK2_50;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge FPGA_CLK2_50);
		$display("Watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
		$display("Testbench failed");
		$finish;
	end

	// Every reply is due one cycle after its grant
	always @(negedge FPGA_CLK2_50) begin
		if (vid_rd_data_valid) begin
			if (exp_q.size() == 0) begin
				$display("Video reply arrived without a granted request in %s", test_name);
				rd_err_count++;
			end else begin
				exp_byte = exp_q.pop_front();
				if (vid_rd_data !== exp_byte) begin
					$display("ERR %s: expected %h, actual %h", test_name, exp_byte, vid_rd_data);
					rd_err_count++;
				end
			end
		end
		if (vid_rd_ready) begin
			exp_q.push_back(mem_model[vid_rd_addr]);
			rd_count++;
		end
	end

	// ==================================================
	// Helper tasks
	// ==================================================
	task automatic idle_cycles(input int n);
		repeat (n) @(posedge FPGA_CLK2_50);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERR %s %s: expected %h, actual %h", test_name, name, exp, act);
		err_count++;
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		@(negedge FPGA_CLK2_50);
		while (gp_in[17] !== level && n < ack_limit) begin
			@(negedge FPGA_CLK2_50);
			n++;
		end
		if (gp_in[17] !== level) begin
			$display("Host strobe not acknowledged within %0d cycles in %s", ack_limit, test_name);
			err_count++;
		end
	endtask

	// Rising strobe carries the word, falling strobe closes the handshake
	task automatic send_word(input logic [15:0] data);
		@(posedge FPGA_CLK2_50);
		gp_out[15:0] <= data;
		gp_out[17]   <= 1'b1;
		wait_ack(1'b1);
		@(posedge FPGA_CLK2_50);
		gp_out[17] <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic begin_frame(input logic [7:0] cmd);
		@(posedge FPGA_CLK2_50);
		gp_out[20] <= 1'b1;
		send_word({8'h00, cmd});
	endtask

	task automatic end_frame;
		@(posedge FPGA_CLK2_50);
		gp_out[20] <= 1'b0;
		idle_cycles(6);
	endtask

	task automatic video_read(input logic [7:0] addr);
		int n;
		@(posedge FPGA_CLK2_50);
		vid_rd_valid <= 1'b1;
		vid_rd_addr  <= addr;
		n = 0;
		@(negedge FPGA_CLK2_50);
		while (!vid_rd_ready && n < rd_limit) begin
			@(negedge FPGA_CLK2_50);
			n++;
		end
		if (!vid_rd_ready) begin
			$display("Video read of address %h not granted within %0d cycles", addr, rd_limit);
			err_count++;
		end
		@(posedge FPGA_CLK2_50);
		vid_rd_valid <= 1'b0;
		@(negedge FPGA_CLK2_50);
	endtask

	// Code travels through four register stages before reset_req moves
	task automatic apply_code(input logic [1:0] code);
		@(posedge FPGA_CLK2_50);
		gp_out[31:30] <= code;
		idle_cycles(6);
		@(negedge FPGA_CLK2_50);
	endtask

	task automatic start_test(input string name);
		test_name     = name;
		errs_at_start = err_count + rd_err_count;
	endtask

	task automatic finish_test;
		int errs;
		errs = err_count + rd_err_count - errs_at_start;
		if (errs == 0) begin
			pass_count++;
			$display("Test %s: ok", test_name);
		end else begin
			fail_count++;
			$display("Test %s: FAIL with %0d errors", test_name, errs);
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		void'($urandom(18));
		err_count     = 0;
		pass_count    = 0;
		fail_count    = 0;
		hammer_on     = 1'b0;
		test_name     = "reset";
		resetd       <= 1'b1;
		gp_out       <= '0;
		btn_user_n   <= 1'b1;
		btn_osd_n    <= 1'b1;
		key          <= 2'b11;
		vid_rd_valid <= 1'b0;
		vid_rd_addr  <= '0;
		led_power_st <= '0;
		led_disk_st  <= '0;
		led_user_st  <= 1'b0;
		repeat (5) @(posedge FPGA_CLK2_50);
		resetd <= 1'b0;
		idle_cycles(2);
		@(negedge FPGA_CLK2_50);

		// Identification word and state after reset
		start_test("magic_word");
		if ({cfg_ready, reset_req, vid_rd_data_valid, gp_in[30:29], gp_in[17]} !== 6'd0)
			report_mismatch("reset_state", 32'd0,
				32'({cfg_ready, reset_req, vid_rd_data_valid, gp_in[30:29], gp_in[17]}));
		@(posedge FPGA_CLK2_50);
		gp_out[31] <= 1'b1;
		@(negedge FPGA_CLK2_50);
		if (gp_in !== hps_io_pkg::core_magic)
			report_mismatch("magic_set", hps_io_pkg::core_magic, gp_in);
		@(posedge FPGA_CLK2_50);
		gp_out[31] <= 1'b0;
		@(negedge FPGA_CLK2_50);
		// Bit 31 low and both buttons still released
		if (gp_in[31:29] !== 3'b000)
			report_mismatch("magic_clear", 32'd0, 32'(gp_in[31:29]));
		finish_test();

		// Configuration write then read-back
		start_test("config");
		for (int i = 0; i < 3; i++) begin
			cfg_m = 16'($urandom);
			begin_frame(hps_io_pkg::cmd_cfg_wr);
			send_word(cfg_m);
			end_frame();
			begin_frame(hps_io_pkg::cmd_cfg_rd);
			send_word(16'($urandom));
			end_frame();
			@(negedge FPGA_CLK2_50);
			exp_flags = {cfg_m[6], cfg_m[5], cfg_m[3], cfg_m[2]};
			if (cfg_ready !== 1'b1)
				report_mismatch("cfg_ready", 32'd1, 32'(cfg_ready));
			if ({audio_96k, ypbpr_en, csync, vga_scaler} !== exp_flags)
				report_mismatch("cfg_outputs", 32'(exp_flags),
					32'({audio_96k, ypbpr_en, csync, vga_scaler}));
			if (gp_in[15:0] !== cfg_m)
				report_mismatch("io_dout", 32'(cfg_m), 32'(gp_in[15:0]));
		end
		finish_test();

		// OSD writes into the lower half, then video reads
		start_test("osd_write_read");
		begin_frame(hps_io_pkg::cmd_osd_wr);
		for (int i = 0; i < 60; i++) begin
			addr_v = {1'b0, 7'($urandom)};
			data_v = 8'($urandom);
			mem_model[addr_v] = data_v;
			lo_addrs.push_back(addr_v);
			send_word({addr_v, data_v});
		end
		end_frame();
		for (int i = 0; i < 60; i++)
			video_read(lo_addrs[$urandom % lo_addrs.size()]);
		idle_cycles(2);
		if (exp_q.size() != 0) begin
			$display("Video replies missing, %0d requests unanswered", exp_q.size());
			err_count++;
		end
		finish_test();

		// Video port requests every cycle while the host writes the upper half
		start_test("shared_access");
		rd_start  = rd_count;
		hammer_on = 1'b1;
		fork
			begin
				while (hammer_on) begin
					@(posedge FPGA_CLK2_50);
					vid_rd_valid <= 1'b1;
					vid_rd_addr  <= lo_addrs[$urandom % lo_addrs.size()];
				end
				vid_rd_valid <= 1'b0;
			end
			begin
				begin_frame(hps_io_pkg::cmd_osd_wr);
				for (int i = 0; i < 40; i++) begin
					addr_v = {1'b1, 7'($urandom)};
					data_v = 8'($urandom);
					mem_model[addr_v] = data_v;
					hi_addrs.push_back(addr_v);
					send_word({addr_v, data_v});
				end
				end_frame();
				hammer_on = 1'b0;
			end
		join
		idle_cycles(3);
		if (rd_count == rd_start) begin
			$display("Video port was never granted while the host wrote");
			err_count++;
		end
		foreach (hi_addrs[i])
			video_read(hi_addrs[i]);
		for (int i = 0; i < 10; i++)
			video_read(lo_addrs[$urandom % lo_addrs.size()]);
		idle_cycles(2);
		if (exp_q.size() != 0) begin
			$display("Video replies missing, %0d requests unanswered", exp_q.size());
			err_count++;
		end
		finish_test();

		// Reset request codes, fixed opening and closing around random codes
		start_test("reset_codes");
		prev_code = 2'd0;
		req_m     = 1'b0;
		code_q.push_back(2'd1);
		code_q.push_back(2'd2);
		code_q.push_back(2'd0);
		code_q.push_back(2'd2);
		repeat (20) code_q.push_back(2'($urandom % 4));
		code_q.push_back(2'd0);
		code_q.push_back(2'd2);
		code_q.push_back(2'd0);
		foreach (code_q[i]) begin
			apply_code(code_q[i]);
			if (code_q[i] == 2'd1)
				req_m = 1'b1;
			else if (code_q[i] == 2'd2 && prev_code == 2'd0)
				req_m = 1'b0;
			prev_code = code_q[i];
			if (reset_req !== req_m)
				report_mismatch($sformatf("reset_req step %0d", i), 32'(req_m), 32'(reset_req));
		end
		finish_test();

		// Debounced buttons, then LED drive
		start_test("panel");
		for (int i = 0; i < 6; i++) begin
			bu_n  = 1'($urandom);
			bo_n  = 1'($urandom);
			key_v = 2'($urandom);
			@(posedge FPGA_CLK2_50);
			btn_user_n <= bu_n;
			btn_osd_n  <= bo_n;
			key        <= key_v;
			idle_cycles(11 * (deb_div + 1));
			@(negedge FPGA_CLK2_50);
			// Pressed when the panel pin or its key is low
			if (gp_in[30:29] !== {~bu_n | ~key_v[1], ~bo_n | ~key_v[0]})
				report_mismatch("buttons", 32'({~bu_n | ~key_v[1], ~bo_n | ~key_v[0]}),
					32'(gp_in[30:29]));
		end
		for (int i = 0; i < 16; i++) begin
			ps = 2'($urandom);
			ds = 2'($urandom);
			us = 1'($urandom);
			dr = 1'($urandom);
			@(posedge FPGA_CLK2_50);
			led_power_st <= ps;
			led_disk_st  <= ds;
			led_user_st  <= us;
			gp_out[29]   <= dr;
			idle_cycles(3);
			@(negedge FPGA_CLK2_50);
			exp_led[2] = ps[1] ? ~ps[0] : 1'b0;
			exp_led[1] = ds[1] ? ~ds[0] : (ds[0] | dr);
			exp_led[0] = us;
			if ({led_power, led_disk, led_user} !== exp_led)
				report_mismatch("leds", 32'(exp_led), 32'({led_power, led_disk, led_user}));
		end
		@(posedge FPGA_CLK2_50);
		gp_out[29] <= 1'b0;
		finish_test();

		idle_cycles(2);
		$display("Tests: %0d ok, %0d failing, %0d errors", pass_count, fail_count,
			err_count + rd_err_count);
		if (fail_count == 0 && err_count + rd_err_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* list.f */
hdl/hps_io_pkg.sv
hdl/hps_io_sync.sv
hdl/hps_cmd_decoder.sv
hdl/osd_ram_arbiter.sv
hdl/panel_io.sv
hdl/reset_ctl.sv
hdl/hps_io_top.sv
tb/tb_hps_io.sv

/* run.sh */
#!/bin/sh
# Build and run the host I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_hps_io -Mdir obj_dir -o tb_hps_io_sim \
	-f list.f > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build returned status $status"
	exit 1
fi

./obj_dir/tb_hps_io_sim > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
	echo "Simulation returned status $status"
	exit 1
fi

if grep -q "Testbench failed" "$sim_log"; then
	exit 1
fi
exit 0
